/* include/rename_config.svh */
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// datapath width
`define XLEN        32

// architectural register file, r0 hardwired to p0
`define ARCH_REGS   8
`define ARCH_LEN    3

// physical register file, p0 never enters the free queue
`define PRF_SIZE    16
`define PRF_LEN     4

`define MUL_CYCLES  3   // cycles a multiply occupies execute

`endif

/* hw/rename_pkg.sv */
`include "rename_config.svh"

package rename_pkg;

    typedef enum logic [2:0] {
        op_nop,
        op_add,
        op_sub,
        op_addi,
        op_mul,
        op_beq
    } opcode_e;

    typedef enum logic {
        mul_idle,
        mul_busy
    } mul_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // stage payloads

    typedef struct packed {
        logic [7:0]           tag;
        opcode_e              op;
        logic [`ARCH_LEN-1:0] dest;
        logic [`ARCH_LEN-1:0] src_a;
        logic [`ARCH_LEN-1:0] src_b;
        logic [`XLEN-1:0]     imm;
    } inst_t;

    typedef struct packed {
        logic                 valid;
        logic [7:0]           tag;
        opcode_e              op;
        logic                 has_dest;
        logic [`ARCH_LEN-1:0] arch_dest;
        logic [`PRF_LEN-1:0]  pdest;       // newly allocated
        logic [`PRF_LEN-1:0]  prev_pdest;  // freed when this commits
        logic [`PRF_LEN-1:0]  psrc_a;
        logic [`PRF_LEN-1:0]  psrc_b;
        logic [`XLEN-1:0]     imm;
    } renamed_t;

    typedef struct packed {
        renamed_t         ren;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
    } issue_t;

    typedef struct packed {
        logic                valid;
        logic [`PRF_LEN-1:0] preg;
        logic [`XLEN-1:0]    value;
    } cdb_t;

    typedef struct packed {
        logic                 valid;
        logic [7:0]           tag;
        logic [`ARCH_LEN-1:0] arch_dest;
        logic [`PRF_LEN-1:0]  pdest;
        logic [`PRF_LEN-1:0]  prev_pdest;
        logic [`XLEN-1:0]     value;
        logic                 has_dest;
        logic                 taken;
    } retire_t;

    typedef struct packed {
        logic [7:0]           tag;
        logic [`ARCH_LEN-1:0] arch_dest;
        logic [`XLEN-1:0]     value;
        logic                 has_dest;
        logic                 taken;
    } commit_t;

    // free queue index step, skips slot 0
    function automatic logic [`PRF_LEN-1:0] next_free_idx(input logic [`PRF_LEN-1:0] idx);
        return (idx == `PRF_LEN'(`PRF_SIZE - 1)) ? `PRF_LEN'(1) : idx + `PRF_LEN'(1);
    endfunction

endpackage

/* hw/rename_stage.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_stage import rename_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 in_valid,
    input  inst_t                                inst_in,
    input  logic [`PRF_LEN-1:0]                  free_preg,
    input  logic                                 free_empty,
    input  logic                                 hold,
    input  logic                                 flush,
    input  logic [`ARCH_REGS-1:0][`PRF_LEN-1:0]  retire_map,
    output logic                                 alloc,
    output logic                                 stall,
    output renamed_t                             renamed
);

    logic [`ARCH_REGS-1:0][`PRF_LEN-1:0] spec_map;   // speculative arch -> phys
    logic                                has_dest;
    logic                                accept;
    renamed_t                            next_ren;

    assign has_dest = inst_in.dest != '0 && inst_in.op != op_nop && inst_in.op != op_beq;
    assign stall    = hold || free_empty;
    assign accept   = in_valid && !stall && !flush;   // input during redirect is dropped
    assign alloc    = accept && has_dest;

    always_comb begin
        next_ren.valid      = 1'b1;
        next_ren.tag        = inst_in.tag;
        next_ren.op         = inst_in.op;
        next_ren.has_dest   = has_dest;
        next_ren.arch_dest  = inst_in.dest;
        next_ren.pdest      = has_dest ? free_preg : '0;
        next_ren.prev_pdest = spec_map[inst_in.dest];
        next_ren.imm        = inst_in.imm;
        // unused sources point at p0, which is always ready
        next_ren.psrc_a = (inst_in.op == op_nop) ? '0 : spec_map[inst_in.src_a];
        next_ren.psrc_b = (inst_in.op == op_nop || inst_in.op == op_addi) ? '0
                                                                          : spec_map[inst_in.src_b];
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_map <= '0;
        end else if (flush) begin
            spec_map <= retire_map;     // back to committed state
        end else if (alloc) begin
            spec_map[inst_in.dest] <= free_preg;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) renamed <= next_ren;
        if (reset || flush) begin
            renamed.valid <= 1'b0;
        end else if (!hold) begin
            renamed.valid <= accept;    // bubble when nothing accepted
        end
    end

endmodule

/* hw/prf.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module prf import rename_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                alloc,
    output logic [`PRF_LEN-1:0] free_preg,
    output logic                free_empty,
    input  logic [`PRF_LEN-1:0] rd_a,
    input  logic [`PRF_LEN-1:0] rd_b,
    output logic [`XLEN-1:0]    val_a,
    output logic [`XLEN-1:0]    val_b,
    output logic                rdy_a,
    output logic                rdy_b,
    input  cdb_t                cdb,
    input  logic                release_valid,
    input  logic [`PRF_LEN-1:0] release_preg,
    input  logic                restore,
    input  logic [`PRF_LEN-1:0] committed_head,
    output logic [`PRF_LEN-1:0] head
);

    logic [`XLEN-1:0]    values [`PRF_SIZE];
    logic [`PRF_SIZE-1:0] ready_bits;
    logic [`PRF_LEN-1:0] free_q [`PRF_SIZE];   // slot 0 unused
    logic [`PRF_LEN-1:0] tail;
    logic [`PRF_LEN-1:0] count;                // entries in the free queue
    logic                rel;
    logic [`PRF_LEN-1:0] tail_n;
    logic [`PRF_LEN-1:0] restore_count;
    logic                hit_a;
    logic                hit_b;

    ////////////////////////////////////////////////////////////////////////////
    // operand read with result bus bypass, p0 reads zero

    assign hit_a = cdb.valid && cdb.preg == rd_a;
    assign hit_b = cdb.valid && cdb.preg == rd_b;
    assign val_a = (rd_a == '0) ? '0 : hit_a ? cdb.value : values[rd_a];
    assign val_b = (rd_b == '0) ? '0 : hit_b ? cdb.value : values[rd_b];
    assign rdy_a = hit_a || ready_bits[rd_a];
    assign rdy_b = hit_b || ready_bits[rd_b];

    ////////////////////////////////////////////////////////////////////////////
    // free queue

    assign free_preg  = free_q[head];
    assign free_empty = count == '0;
    assign rel        = release_valid && release_preg != '0;   // p0 never freed
    assign tail_n     = rel ? next_free_idx(tail) : tail;

    // committed_head..tail is what stays free, equal means full
    assign restore_count = (tail_n > committed_head) ? tail_n - committed_head
                                                     : tail_n - committed_head - `PRF_LEN'(1);

    always_ff @(posedge clock) begin
        if (reset) begin
            head       <= `PRF_LEN'(1);
            tail       <= `PRF_LEN'(1);
            count      <= `PRF_LEN'(`PRF_SIZE - 1);
            ready_bits <= `PRF_SIZE'(1);
            for (int i = 0; i < `PRF_SIZE; i++) free_q[i] <= `PRF_LEN'(i);
        end else begin
            if (rel) free_q[tail] <= release_preg;
            tail <= tail_n;
            if (restore) begin
                head  <= committed_head;   // squashed allocations are still in the queue
                count <= restore_count;
            end else begin
                if (alloc) head <= next_free_idx(head);
                count <= count + `PRF_LEN'(rel) - `PRF_LEN'(alloc);
            end
            if (cdb.valid) ready_bits[cdb.preg] <= 1'b1;
            if (alloc) ready_bits[free_preg] <= 1'b0;   // new owner not produced yet
        end
    end

    always_ff @(posedge clock) begin
        if (cdb.valid) values[cdb.preg] <= cdb.value;
    end

endmodule

/* hw/operand_read_stage.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module operand_read_stage import rename_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                hold,
    input  renamed_t            renamed,
    output logic [`PRF_LEN-1:0] rd_a,
    output logic [`PRF_LEN-1:0] rd_b,
    input  logic [`XLEN-1:0]    val_a,
    input  logic [`XLEN-1:0]    val_b,
    input  logic                rdy_a,
    input  logic                rdy_b,
    output logic                busy,
    output issue_t              issue
);

    logic operands_ready;

    assign rd_a           = renamed.psrc_a;
    assign rd_b           = renamed.psrc_b;
    assign operands_ready = rdy_a && rdy_b;
    assign busy           = hold || (renamed.valid && !operands_ready);   // also passes execute back-pressure

    always_ff @(posedge clock) begin
        if (!hold && renamed.valid && operands_ready) begin
            issue.ren <= renamed;
            issue.a   <= val_a;
            issue.b   <= val_b;
        end
        if (reset || flush) begin
            issue.ren.valid <= 1'b0;
        end else if (!hold) begin
            issue.ren.valid <= renamed.valid && operands_ready;
        end
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module execute_stage import rename_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    flush,
    input  issue_t  issue,
    output logic    busy,
    output cdb_t    cdb,
    output retire_t retire
);

    localparam int cnt_w = $clog2(`MUL_CYCLES);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`MUL_CYCLES - 1);

    mul_state_e       state;
    logic [cnt_w-1:0] cnt;
    logic             is_mul;
    logic             done;
    logic             taken;
    logic [`XLEN-1:0] result;

    assign is_mul = issue.ren.valid && issue.ren.op == op_mul;
    assign busy   = is_mul && !(state == mul_busy && cnt == last_cnt);
    assign done   = issue.ren.valid && !busy;

    always_comb begin
        result = '0;    // nop and beq carry zero
        taken  = 1'b0;
        case (issue.ren.op)
            op_add:  result = issue.a + issue.b;
            op_sub:  result = issue.a - issue.b;
            op_addi: result = issue.a + issue.ren.imm;
            op_mul:  result = issue.a * issue.b;   // low XLEN bits
            op_beq:  taken  = issue.a == issue.b;
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // multiplier sequencing, operands held by read stage meanwhile

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            state <= mul_idle;
            cnt   <= '0;
        end else if (state == mul_idle) begin
            if (is_mul) begin
                state <= mul_busy;
                cnt   <= cnt_w'(1);
            end
        end else if (cnt == last_cnt) begin
            state <= mul_idle;
            cnt   <= '0;
        end else begin
            cnt <= cnt + cnt_w'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (done) begin
            cdb.preg          <= issue.ren.pdest;
            cdb.value         <= result;
            retire.tag        <= issue.ren.tag;
            retire.arch_dest  <= issue.ren.arch_dest;
            retire.pdest      <= issue.ren.pdest;
            retire.prev_pdest <= issue.ren.prev_pdest;
            retire.value      <= result;
            retire.has_dest   <= issue.ren.has_dest;
            retire.taken      <= taken;
        end
        if (reset || flush) begin
            cdb.valid    <= 1'b0;
            retire.valid <= 1'b0;
        end else begin
            cdb.valid    <= done && issue.ren.has_dest;
            retire.valid <= done;
        end
    end

endmodule

/* hw/retire_stage.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module retire_stage import rename_pkg::*; (
    input  logic                                 clock,
    input  logic                                 reset,
    input  retire_t                              retire,
    output logic                                 release_valid,
    output logic [`PRF_LEN-1:0]                  release_preg,
    output logic                                 mispredict,
    output logic [`PRF_LEN-1:0]                  committed_head,
    output logic [`ARCH_REGS-1:0][`PRF_LEN-1:0]  retire_map,
    output logic                                 commit_valid,
    output commit_t                              commit_out
);

    logic commit_en;

    // whatever arrives during the mispredict cycle is younger than the branch
    assign commit_en = retire.valid && !mispredict;

    always_ff @(posedge clock) begin
        if (reset) begin
            retire_map     <= '0;
            committed_head <= `PRF_LEN'(1);
            commit_valid   <= 1'b0;
            release_valid  <= 1'b0;
            mispredict     <= 1'b0;
        end else begin
            commit_valid  <= commit_en;
            release_valid <= commit_en && retire.has_dest;
            mispredict    <= commit_en && retire.taken;
            if (commit_en && retire.has_dest) begin
                retire_map[retire.arch_dest] <= retire.pdest;
                committed_head <= next_free_idx(committed_head);   // tracks prf head
            end
        end
    end

    always_ff @(posedge clock) begin
        if (commit_en) begin
            commit_out.tag       <= retire.tag;
            commit_out.arch_dest <= retire.arch_dest;
            commit_out.value     <= retire.value;
            commit_out.has_dest  <= retire.has_dest;
            commit_out.taken     <= retire.taken;
            release_preg         <= retire.prev_pdest;   // old mapping now dead
        end
    end

endmodule

/* hw/rename_core_top.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_core_top import rename_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    in_valid,
    input  inst_t   inst_in,
    output logic    stall,
    output logic    commit_valid,
    output commit_t commit_out,
    output logic    redirect
);

    logic [`PRF_LEN-1:0]                 free_preg;
    logic                                free_empty;
    logic                                alloc;
    logic                                rd_busy;
    logic                                ex_busy;
    renamed_t                            ren_q;
    issue_t                              iss_q;
    cdb_t                                cdb_bus;
    retire_t                             ret_q;
    logic [`PRF_LEN-1:0]                 rd_a;
    logic [`PRF_LEN-1:0]                 rd_b;
    logic [`XLEN-1:0]                    val_a;
    logic [`XLEN-1:0]                    val_b;
    logic                                rdy_a;
    logic                                rdy_b;
    logic                                release_valid;
    logic [`PRF_LEN-1:0]                 release_preg;
    logic [`PRF_LEN-1:0]                 committed_head;
    logic [`ARCH_REGS-1:0][`PRF_LEN-1:0] retire_map;

    rename_stage u_rename (
        .clock, .reset, .in_valid, .inst_in, .free_preg, .free_empty,
        .hold(rd_busy), .flush(redirect), .retire_map, .alloc, .stall, .renamed(ren_q)
    );

    prf u_prf (
        .clock, .reset, .alloc, .free_preg, .free_empty, .rd_a, .rd_b, .val_a, .val_b,
        .rdy_a, .rdy_b, .cdb(cdb_bus), .release_valid, .release_preg,
        .restore(redirect), .committed_head, .head()
    );

    operand_read_stage u_read (
        .clock, .reset, .flush(redirect), .hold(ex_busy), .renamed(ren_q), .rd_a, .rd_b,
        .val_a, .val_b, .rdy_a, .rdy_b, .busy(rd_busy), .issue(iss_q)
    );

    execute_stage u_exec (
        .clock, .reset, .flush(redirect), .issue(iss_q), .busy(ex_busy), .cdb(cdb_bus),
        .retire(ret_q)
    );

    retire_stage u_retire (
        .clock, .reset, .retire(ret_q), .release_valid, .release_preg,
        .mispredict(redirect), .committed_head, .retire_map, .commit_valid, .commit_out
    );

endmodule

/* testbench/rename_core_chk.sv */
`timescale 1ns/1ns

module rename_core_chk (
    input logic clock,
    input logic reset,
    input logic stall,
    input logic commit_valid,
    input logic redirect
);

    ////////////////////////////////////////////////////////////////////////////
    // redirect and commit spacing

    // every stage is flushed so the next branch needs a full refill
    redirect_single: assert property (
        @(posedge clock) disable iff (reset)
        redirect |-> !($past(redirect, 1) || $past(redirect, 2) || $past(redirect, 3)
                       || $past(redirect, 4))
    ) else $error("redirect high again within 4 cycles of the previous one");

    commit_after_redirect: assert property (
        @(posedge clock) disable iff (reset)
        commit_valid |-> !($past(redirect, 1) || $past(redirect, 2) || $past(redirect, 3))
    ) else $error("commit_valid within 3 cycles after redirect");   // refill takes 4

    ctrl_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown({stall, commit_valid, redirect})
    ) else $error("control output is X or Z after reset");

endmodule

/* testbench/rename_core_tb.sv */
`timescale 1ns/1ns
`include "rename_config.svh"

module rename_core_tb import rename_pkg::*; ();

    localparam int clk_period = 40;
    localparam int num_insts  = 400;
    localparam int timeout_ns = num_insts * (4 + `MUL_CYCLES) * clk_period * 4;

    logic                             clock;
    logic                             reset      = 1'b1;
    logic                             in_valid   = 1'b0;
    inst_t                            inst_in    = '0;
    logic                             stall;
    logic                             commit_valid;
    commit_t                          commit_out;
    logic                             redirect;
    logic [31:0]                      lfsr_state = 32'h2ba0;
    logic [`ARCH_REGS-1:0][`XLEN-1:0] model_regs = '0;   // committed architectural state
    inst_t                            exp_q[$];          // accepted but not yet committed
    logic [7:0]                       next_tag   = '0;
    logic                             accepted   = 1'b0;
    int                               cycle_cnt  = 0;
    int                               sent       = 0;
    int                               commits    = 0;
    int                               squashed   = 0;
    int                               errors     = 0;

    rename_core_top dut (
        .clock(clock), .reset(reset), .in_valid(in_valid), .inst_in(inst_in), .stall(stall),
        .commit_valid(commit_valid), .commit_out(commit_out), .redirect(redirect)
    );

    bind rename_core_top rename_core_chk chk (
        .clock(clock), .reset(reset), .stall(stall), .commit_valid(commit_valid),
        .redirect(redirect)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic make_inst(input logic [7:0] tag, output inst_t inst);
        logic [31:0] r;
        inst.tag = tag;
        take_bits(4, r);
        case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: inst.op = op_add;
            4'd5, 4'd6:                   inst.op = op_sub;
            4'd11, 4'd12:                 inst.op = op_mul;
            4'd13:                        inst.op = op_beq;   // rare so long bursts run between
            4'd14:                        inst.op = op_nop;
            default:                      inst.op = op_addi;
        endcase
        take_bits(`ARCH_LEN, r);
        inst.dest = r[`ARCH_LEN-1:0];   // r0 about one time in eight
        take_bits(`ARCH_LEN, r);
        inst.src_a = r[`ARCH_LEN-1:0];
        take_bits(`ARCH_LEN, r);
        inst.src_b = r[`ARCH_LEN-1:0];
        take_bits(8, r);
        inst.imm = {{(`XLEN - 8){r[7]}}, r[7:0]};
    endtask

    always @(posedge clock) begin : drive
        inst_t       new_inst;
        logic [31:0] gap_bits;
        cycle_cnt <= cycle_cnt + 1;
        reset     <= cycle_cnt < 3;   // high for the first 4 edges
        if (cycle_cnt >= 4 && sent < num_insts) begin
            // a refused instruction is offered again
            if (!in_valid || accepted) begin
                take_bits(2, gap_bits);
                make_inst(next_tag, new_inst);
                in_valid <= gap_bits[1:0] != 2'b00;
                inst_in  <= new_inst;
            end
        end else begin
            in_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model and commit check

    function automatic commit_t expected_commit(input inst_t inst,
                                                input logic [`ARCH_REGS-1:0][`XLEN-1:0] regs);
        commit_t          c;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        a           = regs[inst.src_a];
        b           = regs[inst.src_b];
        c.tag       = inst.tag;
        c.arch_dest = inst.dest;
        c.value     = '0;
        c.taken     = 1'b0;
        c.has_dest  = inst.dest != '0 && inst.op != op_nop && inst.op != op_beq;
        case (inst.op)
            op_add:  c.value = a + b;
            op_sub:  c.value = a - b;
            op_addi: c.value = a + inst.imm;
            op_mul:  c.value = a * b;   // low half only
            op_beq:  c.taken = a == b;
            default: c.value = '0;
        endcase
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        errors++;
        $display("[ERROR] %s expected %h got %h", name, exp_v, got_v);
    endtask

    task automatic check_commit();
        inst_t   inst;
        commit_t exp_c;
        assert (exp_q.size() != 0) else begin
            errors++;
            $display("commit with tag %h arrived with no instruction outstanding",
                     commit_out.tag);
        end
        if (exp_q.size() != 0) begin
            inst  = exp_q.pop_front();
            exp_c = expected_commit(inst, model_regs);
            commits++;
            assert (commit_out.tag == exp_c.tag)
                else report_mismatch("commit_out.tag", 32'(exp_c.tag), 32'(commit_out.tag));
            assert (commit_out.arch_dest == exp_c.arch_dest)
                else report_mismatch("commit_out.arch_dest", 32'(exp_c.arch_dest),
                                     32'(commit_out.arch_dest));
            assert (commit_out.value == exp_c.value)
                else report_mismatch("commit_out.value", 32'(exp_c.value),
                                     32'(commit_out.value));
            assert (commit_out.has_dest == exp_c.has_dest)
                else report_mismatch("commit_out.has_dest", 32'(exp_c.has_dest),
                                     32'(commit_out.has_dest));
            assert (commit_out.taken == exp_c.taken)
                else report_mismatch("commit_out.taken", 32'(exp_c.taken),
                                     32'(commit_out.taken));
            assert (redirect == exp_c.taken)
                else report_mismatch("redirect", 32'(exp_c.taken), 32'(redirect));
            if (exp_c.has_dest) model_regs[exp_c.arch_dest] = exp_c.value;
            if (exp_c.taken) begin   // everything younger gets flushed
                squashed = squashed + exp_q.size();
                exp_q.delete();
            end
        end
    endtask

    // mid-cycle, outputs and the next edge's accept are both settled
    always @(negedge clock) begin : monitor
        if (!reset) begin
            if (commit_valid) begin
                check_commit();
            end else begin
                assert (!redirect) else report_mismatch("redirect", 32'h0, 32'(redirect));
            end
            accepted = in_valid && !stall && !redirect;
            if (accepted) begin
                exp_q.push_back(inst_in);
                sent++;
                next_tag = next_tag + 8'd1;
            end
        end
    end

    task automatic print_summary();
        $display("accepted %0d, committed %0d, squashed %0d, errors %0d",
                 sent, commits, squashed, errors);
    endtask

    initial begin : finish_run
        while (sent < num_insts || exp_q.size() != 0) @(negedge clock);
        repeat (4) @(negedge clock);   // room for a stray commit
        print_summary();
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("watchdog expired with %0d of %0d accepted and %0d still outstanding",
                 sent, num_insts, exp_q.size());
        print_summary();
        $display("Finished with errors");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+include
hw/rename_pkg.sv
hw/rename_stage.sv
hw/prf.sv
hw/operand_read_stage.sv
hw/execute_stage.sv
hw/retire_stage.sv
hw/rename_core_top.sv
testbench/rename_core_chk.sv
testbench/rename_core_tb.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := rename_core_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Finished with no errors

SOURCES  := $(wildcard hw/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
